// File: hw/axi_pkg.sv
package axi_pkg;

  typedef logic [3:0]  axi_id_t;
  typedef logic [7:0]  axi_ids_t;
  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_strb_t;
  typedef logic [3:0]  axi_len_t;
  typedef logic [1:0]  axi_resp_t;

  localparam axi_resp_t   resp_okay    = 2'b00;
  localparam axi_resp_t   resp_slverr  = 2'b10;
  localparam logic [3:0]  master_1_idx = 4'd1;
  localparam int unsigned slave_words  = 256;

  typedef enum logic [1:0] {sel_s0, sel_s1, sel_s2, sel_none} slave_sel_t;
  typedef enum logic [1:0] {lock_no, lock_s0, lock_s1, lock_s2} b_lock_t;

  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } aw_t;

  // Slave side carries the master index in the upper ID nibble
  typedef struct packed {
    axi_ids_t  id;
    axi_addr_t addr;
    axi_len_t  len;
  } aws_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_t;

  typedef struct packed {
    axi_ids_t  id;
    axi_resp_t resp;
  } bs_t;

  function automatic logic [3:0] master_of(axi_ids_t ids);
    return ids[7:4];
  endfunction

  // Address bits 13:12 pick the slave, 1x all land on S2
  function automatic slave_sel_t slave_of(axi_addr_t addr);
    slave_sel_t sel;
    case (addr[13:12])
      2'b00:   sel = sel_s0;
      2'b01:   sel = sel_s1;
      default: sel = sel_s2;
    endcase
    return sel;
  endfunction

endpackage

// File: hw/write_router.sv
module write_router
  import axi_pkg::*;
(
  input  logic clk,
  input  logic rstn,
  // Master side
  input  aw_t  aw,
  input  logic awvalid,
  output logic awready,
  input  w_t   w,
  input  logic wvalid,
  output logic wready,
  // Slave 0
  output aws_t aws_0,
  output logic awvalid_0,
  input  logic awready_0,
  output w_t   w_0,
  output logic wvalid_0,
  input  logic wready_0,
  // Slave 1
  output aws_t aws_1,
  output logic awvalid_1,
  input  logic awready_1,
  output w_t   w_1,
  output logic wvalid_1,
  input  logic wready_1,
  // Slave 2
  output aws_t aws_2,
  output logic awvalid_2,
  input  logic awready_2,
  output w_t   w_2,
  output logic wvalid_2,
  input  logic wready_2,
  output logic wlast_done
);

  slave_sel_t aw_sel;
  slave_sel_t owner;
  logic       live;
  logic       aw_open;
  logic       aw_xfer;
  aws_t       aws_fwd;

  assign aw_sel  = slave_of(aw.addr);
  // No new AW while a burst still owns the W channel
  assign aw_open = live && (owner == sel_none);

  always_comb begin
    aws_fwd.id   = {master_1_idx, aw.id};
    aws_fwd.addr = aw.addr;
    aws_fwd.len  = aw.len;
  end

  assign aws_0 = aws_fwd;
  assign aws_1 = aws_fwd;
  assign aws_2 = aws_fwd;

  assign awvalid_0 = awvalid && aw_open && (aw_sel == sel_s0);
  assign awvalid_1 = awvalid && aw_open && (aw_sel == sel_s1);
  assign awvalid_2 = awvalid && aw_open && (aw_sel == sel_s2);

  always_comb begin
    case (aw_sel)
      sel_s0:  awready = aw_open && awready_0;
      sel_s1:  awready = aw_open && awready_1;
      sel_s2:  awready = aw_open && awready_2;
      default: awready = 1'b0;
    endcase
  end

  assign aw_xfer = awvalid && awready;

  // W follows the registered owner
  assign w_0 = w;
  assign w_1 = w;
  assign w_2 = w;

  assign wvalid_0 = wvalid && (owner == sel_s0);
  assign wvalid_1 = wvalid && (owner == sel_s1);
  assign wvalid_2 = wvalid && (owner == sel_s2);

  always_comb begin
    case (owner)
      sel_s0:  wready = wready_0;
      sel_s1:  wready = wready_1;
      sel_s2:  wready = wready_2;
      default: wready = 1'b0;
    endcase
  end

  assign wlast_done = wvalid && wready && w.last;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      live  <= 1'b0;
      owner <= sel_none;
    end else begin
      live <= 1'b1;
      if (aw_xfer) begin
        owner <= aw_sel;
      end else if (wlast_done) begin
        owner <= sel_none;
      end
    end
  end

endmodule

// File: hw/b_router.sv
module b_router
  import axi_pkg::*;
(
  input  logic clk,
  input  logic rstn,
  // Slave 0
  input  bs_t  bs_0,
  input  logic bvalid_0,
  output logic bready_0,
  // Slave 1
  input  bs_t  bs_1,
  input  logic bvalid_1,
  output logic bready_1,
  // Slave 2
  input  bs_t  bs_2,
  input  logic bvalid_2,
  output logic bready_2,
  input  logic wlast_done,
  // Master side
  output b_t   b,
  output logic bvalid,
  input  logic bready
);

  b_lock_t    lock_q;
  b_lock_t    lock_d;
  logic [1:0] pend_q;
  logic       b_enable;
  bs_t        bs_sel;
  logic       bvalid_sel;
  logic       bready_sel;
  logic       b_xfer;

  // Bursts whose data is done but whose response has not gone out
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      pend_q <= 2'd0;
    end else begin
      case ({wlast_done, b_xfer})
        2'b10:   pend_q <= pend_q + 2'd1;
        2'b01:   pend_q <= pend_q - 2'd1;
        default: pend_q <= pend_q;
      endcase
    end
  end

  assign b_enable = (pend_q != 2'd0);

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock_q <= lock_no;
    end else begin
      lock_q <= lock_d;
    end
  end

  // Rotate to the next waiting slave after each transfer
  always_comb begin
    lock_d = lock_q;
    unique case (lock_q)
      lock_s0: if (b_xfer) lock_d = bvalid_1 ? lock_s1 : (bvalid_2 ? lock_s2 : lock_no);
      lock_s1: if (b_xfer) lock_d = bvalid_2 ? lock_s2 : (bvalid_0 ? lock_s0 : lock_no);
      lock_s2: if (b_xfer) lock_d = bvalid_0 ? lock_s0 : (bvalid_1 ? lock_s1 : lock_no);
      lock_no: begin
        if (b_enable) begin
          if (bvalid_0) lock_d = lock_s0;
          else if (bvalid_1) lock_d = lock_s1;
          else if (bvalid_2) lock_d = lock_s2;
        end
      end
    endcase
  end

  // Mux from the locked slave
  always_comb begin
    bs_sel.id   = '0;
    bs_sel.resp = resp_slverr;
    bvalid_sel  = 1'b0;
    unique case (lock_q)
      lock_s0: begin
        bs_sel     = bs_0;
        bvalid_sel = bvalid_0;
      end
      lock_s1: begin
        bs_sel     = bs_1;
        bvalid_sel = bvalid_1;
      end
      lock_s2: begin
        bs_sel     = bs_2;
        bvalid_sel = bvalid_2;
      end
      lock_no: ;
    endcase
  end

  assign bready_0 = (lock_q == lock_s0) && bready_sel;
  assign bready_1 = (lock_q == lock_s1) && bready_sel;
  assign bready_2 = (lock_q == lock_s2) && bready_sel;

  // Master decode, other masters never see their response here
  always_comb begin
    b.id       = '0;
    b.resp     = resp_slverr;
    bvalid     = 1'b0;
    bready_sel = 1'b0;
    if (master_of(bs_sel.id) == master_1_idx) begin
      b.id       = bs_sel.id[3:0];
      b.resp     = bs_sel.resp;
      bvalid     = bvalid_sel;
      bready_sel = bready;
    end
  end

  assign b_xfer = bvalid && bready;

endmodule

// File: hw/write_slave.sv
module write_slave
  import axi_pkg::*;
#(
  parameter int unsigned region_base = 0,
  parameter int unsigned resp_delay  = 1
) (
  input  logic clk,
  input  logic rstn,
  input  aws_t aws,
  input  logic awvalid,
  output logic awready,
  input  w_t   w,
  input  logic wvalid,
  output logic wready,
  output bs_t  bs,
  output logic bvalid,
  input  logic bready
);

  typedef enum logic [1:0] {s_idle, s_data, s_wait, s_resp} slave_state_t;

  slave_state_t state;
  axi_ids_t     id_q;
  logic [11:0]  word_q;
  axi_len_t     len_q;
  axi_len_t     beat_q;
  logic         err_q;
  logic [3:0]   delay_q;
  logic [12:0]  cur_word;
  logic         beat_err;
  logic         aw_xfer;
  logic         w_xfer;

  assign awready = (state == s_idle);
  assign wready  = (state == s_data);
  assign bvalid  = (state == s_resp);

  assign aw_xfer = awvalid && awready;
  assign w_xfer  = wvalid && wready;

  // Word index of this beat, relative to the region start
  assign cur_word = {1'b0, word_q} + 13'(beat_q);

  // Past the region end, empty strobe, or last not on the expected beat
  assign beat_err = (cur_word >= 13'(slave_words)) || (w.strb == '0) ||
                    (w.last != (beat_q == len_q));

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      state   <= s_idle;
      delay_q <= 4'd0;
    end else begin
      unique case (state)
        s_idle: if (aw_xfer) state <= s_data;
        s_data: begin
          if (w_xfer && w.last) begin
            state   <= s_wait;
            delay_q <= 4'(resp_delay - 1);
          end
        end
        s_wait: begin
          if (delay_q == 4'd0) state <= s_resp;
          else delay_q <= delay_q - 4'd1;
        end
        s_resp: if (bready) state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_xfer) begin
      id_q   <= aws.id;
      word_q <= aws.addr[13:2] - (12'(region_base) << 10);
      len_q  <= aws.len;
      beat_q <= '0;
      err_q  <= 1'b0;
    end else if (w_xfer) begin
      beat_q <= beat_q + 4'd1;
      err_q  <= err_q || beat_err;
    end
  end

  assign bs.id   = id_q;
  assign bs.resp = err_q ? resp_slverr : resp_okay;

endmodule

// File: hw/axi_write_sub.sv
module axi_write_sub
  import axi_pkg::*;
(
  input  logic clk,
  input  logic rstn,
  input  aw_t  aw,
  input  logic awvalid,
  output logic awready,
  input  w_t   w,
  input  logic wvalid,
  output logic wready,
  output b_t   b,
  output logic bvalid,
  input  logic bready
);

  aws_t aws_0;
  aws_t aws_1;
  aws_t aws_2;
  logic awvalid_0;
  logic awvalid_1;
  logic awvalid_2;
  logic awready_0;
  logic awready_1;
  logic awready_2;
  w_t   w_0;
  w_t   w_1;
  w_t   w_2;
  logic wvalid_0;
  logic wvalid_1;
  logic wvalid_2;
  logic wready_0;
  logic wready_1;
  logic wready_2;
  bs_t  bs_0;
  bs_t  bs_1;
  bs_t  bs_2;
  logic bvalid_0;
  logic bvalid_1;
  logic bvalid_2;
  logic bready_0;
  logic bready_1;
  logic bready_2;
  logic wlast_done;

  write_router write_router_inst (.*);

  write_slave #(.region_base(0), .resp_delay(2)) write_slave_0_inst (
    .clk, .rstn,
    .aws(aws_0), .awvalid(awvalid_0), .awready(awready_0),
    .w(w_0), .wvalid(wvalid_0), .wready(wready_0),
    .bs(bs_0), .bvalid(bvalid_0), .bready(bready_0)
  );

  write_slave #(.region_base(1), .resp_delay(5)) write_slave_1_inst (
    .clk, .rstn,
    .aws(aws_1), .awvalid(awvalid_1), .awready(awready_1),
    .w(w_1), .wvalid(wvalid_1), .wready(wready_1),
    .bs(bs_1), .bvalid(bvalid_1), .bready(bready_1)
  );

  write_slave #(.region_base(2), .resp_delay(1)) write_slave_2_inst (
    .clk, .rstn,
    .aws(aws_2), .awvalid(awvalid_2), .awready(awready_2),
    .w(w_2), .wvalid(wvalid_2), .wready(wready_2),
    .bs(bs_2), .bvalid(bvalid_2), .bready(bready_2)
  );

  b_router b_router_inst (.*);

endmodule

// File: tb/axi_write_sub_sva.sv
module axi_write_sub_sva
  import axi_pkg::*;
(
  input logic             clk,
  input logic             rstn,
  input logic             awvalid,
  input logic             awready,
  input w_t               w,
  input logic             wvalid,
  input logic             wready,
  input b_t               b,
  input logic             bvalid,
  input logic             bready,
  input logic [15:0]      pending,
  input axi_resp_t [15:0] exp_resp
);

  int unsigned fail_count = 0;
  logic        aw_seen;
  logic        wlast_seen;
  logic        burst_open;
  logic        aw_xfer;
  logic        wlast_xfer;
  logic        b_xfer;

  assign aw_xfer    = awvalid && awready;
  assign wlast_xfer = wvalid && wready && w.last;
  assign b_xfer     = bvalid && bready;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      aw_seen    <= 1'b0;
      wlast_seen <= 1'b0;
      burst_open <= 1'b0;
    end else begin
      if (aw_xfer) aw_seen <= 1'b1;
      if (wlast_xfer) wlast_seen <= 1'b1;
      // Open from the AW transfer up to its W last transfer
      if (aw_xfer) burst_open <= 1'b1;
      else if (wlast_xfer) burst_open <= 1'b0;
    end
  end

  b_quiet: assert property (@(posedge clk) (!rstn || !wlast_seen) |-> !bvalid)
    else begin
      fail_count++;
      $error("FAIL %0t bvalid got 1 expected 0 before the first W last", $time);
    end

  w_quiet: assert property (@(posedge clk) (!rstn || !aw_seen) |-> !wready)
    else begin
      fail_count++;
      $error("FAIL %0t wready got 1 expected 0 before the first AW", $time);
    end

  b_id_pending: assert property (@(posedge clk) disable iff (!rstn)
    b_xfer |-> pending[b.id])
    else begin
      fail_count++;
      $error("FAIL %0t pending[b.id] got 0 expected 1 for b.id %0d", $time, $sampled(b.id));
    end

  b_resp_match: assert property (@(posedge clk) disable iff (!rstn)
    b_xfer |-> (b.resp == exp_resp[b.id]))
    else begin
      fail_count++;
      $error("FAIL %0t b.resp got %0h expected %0h", $time, $sampled(b.resp),
             $sampled(exp_resp[b.id]));
    end

  // Stalled response keeps valid and payload
  b_hold: assert property (@(posedge clk) disable iff (!rstn)
    (bvalid && !bready) |=> (bvalid && $stable(b)))
    else begin
      fail_count++;
      $error("FAIL %0t b got %0h expected %0h", $time, $sampled(b), $past(b));
    end

  aw_blocked: assert property (@(posedge clk) disable iff (!rstn) burst_open |-> !awready)
    else begin
      fail_count++;
      $error("FAIL %0t awready got 1 expected 0 while a burst is open", $time);
    end

endmodule

// File: tb/axi_write_sub_tb.sv
module axi_write_sub_tb
  import axi_pkg::*;
();

  localparam int burst_count    = 60;
  localparam int timeout_cycles = burst_count * (16 + 40) + 400;

  logic             clk;
  logic             rstn;
  aw_t              aw;
  logic             awvalid;
  logic             awready;
  w_t               w;
  logic             wvalid;
  logic             wready;
  b_t               b;
  logic             bvalid;
  logic             bready;
  logic [15:0]      pending;
  axi_resp_t [15:0] exp_resp;
  axi_resp_t        next_resp;
  logic [31:0]      rng;
  int               resp_count;
  int               cycle_count;
  int               errors;

  axi_write_sub axi_write_sub_inst (.*);

  bind axi_write_sub axi_write_sub_sva axi_write_sub_sva_inst (
    .clk, .rstn, .awvalid, .awready, .w, .wvalid, .wready, .b, .bvalid, .bready,
    .pending(axi_write_sub_tb.pending),
    .exp_resp(axi_write_sub_tb.exp_resp)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Random B stalls
  initial begin
    logic [31:0] stall_rng;
    bready    = 1'b0;
    stall_rng = xorshift32(32'h8280);
    forever begin
      @(negedge clk);
      stall_rng = xorshift32(stall_rng);
      bready    = (stall_rng[1:0] != 2'b00);
    end
  end

  // Expected table filled on AW and cleared on B
  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pending    <= '0;
      exp_resp   <= '0;
      resp_count <= 0;
    end else begin
      if (awvalid && awready) begin
        pending[aw.id]  <= 1'b1;
        exp_resp[aw.id] <= next_resp;
      end
      if (bvalid && bready) begin
        pending[b.id] <= 1'b0;
        resp_count    <= resp_count + 1;
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run stopped by the timeout after %0d cycles", cycle_count);
    $display("tests failed");
    $finish;
  end

  task automatic send_burst(input aw_t req, input axi_strb_t [15:0] strbs);
    awvalid = 1'b1;
    aw      = req;
    @(posedge clk);
    while (!awready) @(posedge clk);
    for (int i = 0; i <= int'(req.len); i++) begin
      @(negedge clk);
      awvalid = 1'b0;
      rng     = xorshift32(rng);
      w       = '{data: rng, strb: strbs[i], last: (i == int'(req.len))};
      wvalid  = 1'b1;
      @(posedge clk);
      while (!wready) @(posedge clk);
    end
    @(negedge clk);
    wvalid = 1'b0;
  endtask

  initial begin
    axi_id_t          id;
    axi_len_t         len;
    logic [1:0]       region;
    logic [9:0]       offset;
    logic             zero_strb;
    axi_strb_t [15:0] strbs;
    int               sva_fails;
    rstn      = 1'b0;
    aw        = '0;
    awvalid   = 1'b0;
    w         = '0;
    wvalid    = 1'b0;
    next_resp = resp_okay;
    rng       = 32'h8280;
    errors    = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    for (int n = 0; n < burst_count; n++) begin
      @(negedge clk);
      rng    = xorshift32(rng);
      id     = rng[3:0];
      region = 2'(rng[7:4] % 3);
      len    = rng[11:8];
      // About one burst in four runs past the region end
      if (rng[13:12] == 2'b00) offset = 10'(slave_words) - 10'(len) + 10'(rng[16:14]);
      else offset = 10'(rng[23:16] % (slave_words - 15));
      while (pending[id]) id = id + 4'd1;
      zero_strb = 1'b0;
      for (int i = 0; i < 16; i++) begin
        rng      = xorshift32(rng);
        strbs[i] = (rng[4:0] == 5'd0) ? 4'h0 : (rng[8:5] | 4'h1);
        if (i <= int'(len) && strbs[i] == 4'h0) zero_strb = 1'b1;
      end
      next_resp = ((int'(offset) + int'(len) >= slave_words) || zero_strb) ?
                  resp_slverr : resp_okay;
      send_burst('{id: id, addr: {18'd0, region, offset, 2'b00}, len: len}, strbs);
      rng = xorshift32(rng);
      if (rng[2:0] == 3'd0) repeat (int'(rng[6:3])) @(negedge clk);
    end
    while (resp_count < burst_count) @(posedge clk);
    repeat (20) @(posedge clk);
    if (pending != '0) begin
      $display("No response arrived for the IDs in mask %h", pending);
      errors++;
    end
    if (resp_count != burst_count) begin
      $display("Got %0d responses for %0d bursts", resp_count, burst_count);
      errors++;
    end
    sva_fails = axi_write_sub_inst.axi_write_sub_sva_inst.fail_count;
    $display("Assertion failures: %0d, other errors: %0d", sva_fails, errors);
    if (sva_fails == 0 && errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: list.f
hw/axi_pkg.sv
hw/write_router.sv
hw/b_router.sv
hw/write_slave.sv
hw/axi_write_sub.sv
tb/axi_write_sub_sva.sv
tb/axi_write_sub_tb.sv

// File: Bender.yml
package:
  name: axi_write_sub

sources:
  - hw/axi_pkg.sv
  - hw/write_router.sv
  - hw/b_router.sv
  - hw/write_slave.sv
  - hw/axi_write_sub.sv
  - target: test
    files:
      - tb/axi_write_sub_sva.sv
      - tb/axi_write_sub_tb.sv
